// File: logic/bridgePkg.sv
// shared widths, AXI response and burst codes
// APB slave address map
// sequencer state codes
// queue entry and APB request structs
`default_nettype none

package bridgePkg;

  localparam int addrWidth = 32;
  localparam int dataWidth = 32;
  localparam int strbWidth = 4;
  localparam int idWidth   = 8;
  localparam int lenWidth  = 8;
  localparam int slaveNum  = 4;
  localparam int fifoDepth = 4;

  // slave i owns [i*0x1000, i*0x1000 + 0xfff]
  localparam logic [slaveNum-1:0][addrWidth-1:0] slaveBase = {
    32'h0000_3000, 32'h0000_2000, 32'h0000_1000, 32'h0000_0000
  };
  localparam logic [addrWidth-1:0] slaveSize = 32'h0000_1000;

  localparam logic [1:0] respOkay   = 2'd0;
  localparam logic [1:0] respSlvErr = 2'd2;
  localparam logic [1:0] respDecErr = 2'd3;

  localparam logic [1:0] burstFixed = 2'd0;
  localparam logic [1:0] burstIncr  = 2'd1;

  // wait holds a granted burst until its beat can start
  localparam logic [1:0] stIdle   = 2'd0;
  localparam logic [1:0] stWait   = 2'd1;
  localparam logic [1:0] stSetup  = 2'd2;
  localparam logic [1:0] stAccess = 2'd3;

  typedef struct packed {
    logic [addrWidth-1:0] addr;
    logic [idWidth-1:0]   id;
    logic [lenWidth-1:0]  len;
    logic [1:0]           burst;
    logic [2:0]           prot;
  } axiAddrT;

  typedef struct packed {
    logic [dataWidth-1:0] data;
    logic [strbWidth-1:0] strb;
  } axiWrDataT;

  typedef struct packed {
    logic [dataWidth-1:0] data;
    logic [1:0]           resp;
    logic [idWidth-1:0]   id;
    logic                 last;
  } axiRdRespT;

  typedef struct packed {
    logic [addrWidth-1:0] paddr;
    logic [dataWidth-1:0] pwdata;
    logic [strbWidth-1:0] pstrb;
    logic [2:0]           pprot;
    logic                 pwrite;
    logic                 penable;
  } apbReqT;

endpackage

`default_nettype wire

// File: logic/syncFifo.sv
// generic synchronous FIFO
// circular buffer with read/write pointers and an entry count
// push when full and pop when empty are dropped
`timescale 1ns/1ps
`default_nettype none

module syncFifo #(
  parameter int width = 8,
  parameter int depth = 4
) (
  input  wire              pclk,
  input  wire              preset_n,
  input  wire              push,
  input  wire              pop,
  input  wire [width-1:0]  din,
  output logic [width-1:0] dout,
  output logic             full,
  output logic             empty
);

  logic [width-1:0]         mem [depth];
  logic [$clog2(depth)-1:0] wrPtr;
  logic [$clog2(depth)-1:0] rdPtr;
  logic [$clog2(depth):0]   count;
  logic                     doPush;
  logic                     doPop;

  assign doPush = push && !full;
  assign doPop  = pop && !empty;
  assign full   = (count == depth[$clog2(depth):0]);
  assign empty  = (count == '0);
  assign dout   = mem[rdPtr];

  always_ff @(posedge pclk) begin
    if (doPush) begin
      mem[wrPtr] <= din;
    end
  end

  always_ff @(posedge pclk or negedge preset_n) begin
    if (!preset_n) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) begin
        wrPtr <= (int'(wrPtr) == depth - 1) ? '0 : wrPtr + 1'b1;
      end
      if (doPop) begin
        rdPtr <= (int'(rdPtr) == depth - 1) ? '0 : rdPtr + 1'b1;
      end
      case ({doPush, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/axiIngress.sv
// AXI input side
// write address, write data and read address queues
// each channel is ready while its queue has room
`timescale 1ns/1ps
`default_nettype none

module axiIngress (
  input  wire                   pclk,
  input  wire                   preset_n,
  input  wire                   awvalid,
  input  wire bridgePkg::axiAddrT   awReq,
  output logic                  awready,
  input  wire                   wvalid,
  input  wire bridgePkg::axiWrDataT wBeat,
  output logic                  wready,
  input  wire                   arvalid,
  input  wire bridgePkg::axiAddrT   arReq,
  output logic                  arready,
  output bridgePkg::axiAddrT    awHead,
  output bridgePkg::axiWrDataT  wHead,
  output bridgePkg::axiAddrT    arHead,
  output logic                  awPending,
  output logic                  wPending,
  output logic                  arPending,
  input  wire                   awPop,
  input  wire                   wPop,
  input  wire                   arPop
);
  import bridgePkg::*;

  logic awFull;
  logic wFull;
  logic arFull;
  logic awEmpty;
  logic wEmpty;
  logic arEmpty;

  assign awready   = !awFull;
  assign wready    = !wFull;
  assign arready   = !arFull;
  assign awPending = !awEmpty;
  assign wPending  = !wEmpty;
  assign arPending = !arEmpty;

  syncFifo #(.width($bits(axiAddrT)), .depth(fifoDepth)) awFifo (
    .pclk, .preset_n, .push(awvalid && awready), .pop(awPop),
    .din(awReq), .dout(awHead), .full(awFull), .empty(awEmpty)
  );

  syncFifo #(.width($bits(axiWrDataT)), .depth(fifoDepth)) wFifo (
    .pclk, .preset_n, .push(wvalid && wready), .pop(wPop),
    .din(wBeat), .dout(wHead), .full(wFull), .empty(wEmpty)
  );

  syncFifo #(.width($bits(axiAddrT)), .depth(fifoDepth)) arFifo (
    .pclk, .preset_n, .push(arvalid && arready), .pop(arPop),
    .din(arReq), .dout(arHead), .full(arFull), .empty(arEmpty)
  );

endmodule

`default_nettype wire

// File: logic/slaveDecoder.sv
// APB slave decode
// start address to one-hot slave select over the package map
// slave reply mux, masked by the registered psel
// out-of-map bursts complete at once with an error and zero data
`timescale 1ns/1ps
`default_nettype none

module slaveDecoder (
  input  wire  [bridgePkg::addrWidth-1:0]                     startAddr,
  input  wire  [bridgePkg::slaveNum-1:0]                      psel,
  output logic [bridgePkg::slaveNum-1:0]                      sel,
  output logic                                                outOfMap,
  input  wire  [bridgePkg::slaveNum-1:0]                      pready,
  input  wire  [bridgePkg::slaveNum-1:0]                      pslverr,
  input  wire  [bridgePkg::slaveNum-1:0][bridgePkg::dataWidth-1:0] prdata,
  output logic                                                beatReady,
  output logic                                                beatErr,
  output logic [bridgePkg::dataWidth-1:0]                     beatData
);
  import bridgePkg::*;

  // unsigned offset check covers both window edges
  always_comb begin
    for (int i = 0; i < slaveNum; i++) begin
      sel[i] = (startAddr - slaveBase[i]) < slaveSize;
    end
  end

  assign outOfMap = !(|sel);

  always_comb begin
    beatReady = outOfMap;
    beatErr   = outOfMap;
    beatData  = '0;
    for (int i = 0; i < slaveNum; i++) begin
      if (psel[i]) begin
        beatReady = beatReady | pready[i];
        beatErr   = beatErr | pslverr[i];
        beatData  = beatData | prdata[i];
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/apbSequencer.sv
// burst sequencer between the AXI queues and the APB bus
// read/write arbitration, alternating when both are pending
// beat counter, INCR/FIXED address stepping
// APB setup/access FSM with per-beat back-pressure
// sticky write response, per-beat read response
`timescale 1ns/1ps
`default_nettype none

module apbSequencer (
  input  wire                             pclk,
  input  wire                             preset_n,
  input  wire bridgePkg::axiAddrT         awHead,
  input  wire bridgePkg::axiWrDataT       wHead,
  input  wire bridgePkg::axiAddrT         arHead,
  input  wire                             awPending,
  input  wire                             wPending,
  input  wire                             arPending,
  output logic                            awPop,
  output logic                            wPop,
  output logic                            arPop,
  output logic [bridgePkg::addrWidth-1:0] startAddr,
  input  wire  [bridgePkg::slaveNum-1:0]  sel,
  input  wire                             outOfMap,
  input  wire                             beatReady,
  input  wire                             beatErr,
  input  wire  [bridgePkg::dataWidth-1:0] beatData,
  output logic [bridgePkg::slaveNum-1:0]  psel,
  output bridgePkg::apbReqT               apbReq,
  output logic                            rdPush,
  output bridgePkg::axiRdRespT            rdBeat,
  output logic                            wrDone,
  output logic [1:0]                      bResp,
  output logic [bridgePkg::idWidth-1:0]   bId,
  input  wire                             rdSpace,
  input  wire                             bBusy
);
  import bridgePkg::*;

  logic [1:0]          state;
  logic                grantWr;
  logic                lastWr;
  axiAddrT             cur;
  logic [lenWidth-1:0] beatCnt;
  logic                wrReq;
  logic                rdReq;
  logic                pickWr;
  logic                grant;
  logic                beatOk;
  logic                beatEnd;
  logic                lastBeat;

  // ======================================================================
  // arbitration and beat conditions
  // ======================================================================
  assign wrReq    = awPending && !bBusy;
  assign rdReq    = arPending;
  assign pickWr   = wrReq && (!rdReq || !lastWr);
  // hold off while the finished write still sits at the queue head
  assign grant    = (state == stIdle) && !wrDone && (wrReq || rdReq);
  assign beatOk   = grantWr ? wPending : rdSpace;
  assign beatEnd  = (state == stAccess) && beatReady;
  assign lastBeat = (beatCnt == cur.len);

  assign startAddr = cur.addr;
  assign wPop      = (state == stWait) && beatOk && grantWr;
  assign arPop     = beatEnd && lastBeat && !grantWr;
  assign awPop     = wrDone;
  assign rdPush    = beatEnd && !grantWr;
  assign bId       = cur.id;

  always_comb begin
    rdBeat.data = beatData;
    rdBeat.id   = cur.id;
    rdBeat.last = lastBeat;
    if (outOfMap) begin
      rdBeat.resp = respDecErr;
    end else if (beatErr) begin
      rdBeat.resp = respSlvErr;
    end else begin
      rdBeat.resp = respOkay;
    end
  end

  always_ff @(posedge pclk) begin
    if (grant) begin
      cur <= pickWr ? awHead : arHead;
    end
  end

  // ======================================================================
  // APB state machine
  // ======================================================================
  always_ff @(posedge pclk or negedge preset_n) begin
    if (!preset_n) begin
      state   <= stIdle;
      grantWr <= 1'b0;
      lastWr  <= 1'b0;
      beatCnt <= '0;
      bResp   <= respOkay;
      wrDone  <= 1'b0;
      psel    <= '0;
      apbReq  <= '0;
    end else begin
      wrDone <= 1'b0;
      case (state)
        stIdle: begin
          if (grant) begin
            grantWr       <= pickWr;
            lastWr        <= pickWr;
            beatCnt       <= '0;
            bResp         <= respOkay;
            apbReq.paddr  <= pickWr ? awHead.addr : arHead.addr;
            apbReq.pprot  <= pickWr ? awHead.prot : arHead.prot;
            apbReq.pwrite <= pickWr;
            state         <= stWait;
          end
        end
        stWait: begin
          if (beatOk) begin
            psel          <= sel;
            apbReq.pwdata <= grantWr ? wHead.data : '0;
            apbReq.pstrb  <= grantWr ? wHead.strb : '0;
            state         <= stSetup;
          end
        end
        stSetup: begin
          apbReq.penable <= 1'b1;
          state          <= stAccess;
        end
        default: begin
          if (beatReady) begin
            apbReq.penable <= 1'b0;
            // decode error holds for the whole burst, so it always wins
            if (grantWr && outOfMap) begin
              bResp <= respDecErr;
            end else if (grantWr && beatErr) begin
              bResp <= respSlvErr;
            end
            if (lastBeat) begin
              psel   <= '0;
              wrDone <= grantWr;
              state  <= stIdle;
            end else begin
              beatCnt <= beatCnt + 1'b1;
              if (cur.burst == burstIncr) begin
                apbReq.paddr <= apbReq.paddr + addrWidth'(4);
              end
              state <= stWait;
            end
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/axiResponder.sv
// AXI output side
// read beat FIFO feeding the R channel
// single write response register held until bready
`timescale 1ns/1ps
`default_nettype none

module axiResponder (
  input  wire                             pclk,
  input  wire                             preset_n,
  input  wire                             rdPush,
  input  wire bridgePkg::axiRdRespT       rdBeat,
  output logic                            rdSpace,
  output logic                            rvalid,
  output bridgePkg::axiRdRespT            rBeat,
  input  wire                             rready,
  input  wire                             wrDone,
  input  wire  [1:0]                      bResp,
  input  wire  [bridgePkg::idWidth-1:0]   bId,
  output logic                            bBusy,
  output logic                            bvalid,
  output logic [1:0]                      bresp,
  output logic [bridgePkg::idWidth-1:0]   bid,
  input  wire                             bready
);
  import bridgePkg::*;

  logic rdFull;
  logic rdEmpty;

  assign rdSpace = !rdFull;
  assign rvalid  = !rdEmpty;

  syncFifo #(.width($bits(axiRdRespT)), .depth(fifoDepth)) rdFifo (
    .pclk, .preset_n, .push(rdPush), .pop(rvalid && rready),
    .din(rdBeat), .dout(rBeat), .full(rdFull), .empty(rdEmpty)
  );

  // ======================================================================
  // write response channel
  // ======================================================================
  always_ff @(posedge pclk or negedge preset_n) begin
    if (!preset_n) begin
      bvalid <= 1'b0;
    end else if (wrDone) begin
      bvalid <= 1'b1;
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  always_ff @(posedge pclk) begin
    if (wrDone) begin
      bresp <= bResp;
      bid   <= bId;
    end
  end

  // no new write until the master takes this response
  assign bBusy = bvalid;

endmodule

`default_nettype wire

// File: logic/axiApbBridge.sv
// AXI to APB bridge top level
// input queues, burst sequencer with slave decode, response side
`timescale 1ns/1ps
`default_nettype none

module axiApbBridge (
  input  wire                                                 pclk,
  input  wire                                                 preset_n,
  input  wire                                                 awvalid,
  input  wire bridgePkg::axiAddrT                             awReq,
  output logic                                                awready,
  input  wire                                                 wvalid,
  input  wire bridgePkg::axiWrDataT                           wBeat,
  output logic                                                wready,
  input  wire                                                 arvalid,
  input  wire bridgePkg::axiAddrT                             arReq,
  output logic                                                arready,
  output logic                                                rvalid,
  output bridgePkg::axiRdRespT                                rBeat,
  input  wire                                                 rready,
  output logic                                                bvalid,
  output logic [1:0]                                          bresp,
  output logic [bridgePkg::idWidth-1:0]                       bid,
  input  wire                                                 bready,
  output bridgePkg::apbReqT                                   apbReq,
  output logic [bridgePkg::slaveNum-1:0]                      psel,
  input  wire  [bridgePkg::slaveNum-1:0]                      pready,
  input  wire  [bridgePkg::slaveNum-1:0]                      pslverr,
  input  wire  [bridgePkg::slaveNum-1:0][bridgePkg::dataWidth-1:0] prdata
);
  import bridgePkg::*;

  axiAddrT              awHead;
  axiWrDataT            wHead;
  axiAddrT              arHead;
  logic                 awPending;
  logic                 wPending;
  logic                 arPending;
  logic                 awPop;
  logic                 wPop;
  logic                 arPop;
  logic [addrWidth-1:0] startAddr;
  logic [slaveNum-1:0]  sel;
  logic                 outOfMap;
  logic                 beatReady;
  logic                 beatErr;
  logic [dataWidth-1:0] beatData;
  logic                 rdPush;
  axiRdRespT            rdBeat;
  logic                 wrDone;
  logic [1:0]           bResp;
  logic [idWidth-1:0]   bId;
  logic                 rdSpace;
  logic                 bBusy;

  // ======================================================================
  // input side, processing, output side
  // ======================================================================
  axiIngress ingress (.*);

  apbSequencer sequencer (.*);

  slaveDecoder decoder (.*);

  axiResponder responder (.*);

endmodule

`default_nettype wire

// File: dv/bridgeTb.sv
// testbench for the AXI to APB bridge
// clock, reset and AXI master tasks
// four-slave APB word memory with LFSR-driven wait states
// bus protocol assertions and directed burst checks
`timescale 1ns/1ps
`default_nettype none

module bridgeTb;
  import bridgePkg::*;

  localparam int waitLimit = 200;

  logic                               pclk;
  logic                               preset_n;
  logic                               awvalid;
  axiAddrT                            awReq;
  logic                               awready;
  logic                               wvalid;
  axiWrDataT                          wBeat;
  logic                               wready;
  logic                               arvalid;
  axiAddrT                            arReq;
  logic                               arready;
  logic                               rvalid;
  axiRdRespT                          rBeat;
  logic                               rready;
  logic                               bvalid;
  logic [1:0]                         bresp;
  logic [idWidth-1:0]                 bid;
  logic                               bready;
  apbReqT                             apbReq;
  logic [slaveNum-1:0]                psel;
  logic [slaveNum-1:0]                pready;
  logic [slaveNum-1:0]                pslverr;
  logic [slaveNum-1:0][dataWidth-1:0] prdata;

  // slave model state
  logic [dataWidth-1:0] slaveMem [slaveNum][256];
  logic [1:0]           waitLeft [slaveNum];
  logic [15:0]          lfsr;
  logic [2:0]           lastProt;
  logic [addrWidth-1:0] seenAddr [$];
  int                   rdAccesses;
  int                   pselCycles;
  int                   idx;

  int   checks = 0;
  int   errors = 0;
  logic aborted = 1'b0;

  axiApbBridge DUT (.*);

  initial begin
    pclk = 1'b0;
    forever #10 pclk = ~pclk;
  end

  function automatic logic [15:0] lfsrStep(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] fillWord(logic [31:0] addr);
    return (addr * 32'h9E37_79B9) ^ 32'h5A5A_0F0F;
  endfunction

  // ======================================================================
  // APB slave model
  // slave 2 answers every access with an error
  // ======================================================================
  initial begin
    pready     = '0;
    pslverr    = '0;
    prdata     = '0;
    lfsr       = 16'd11;
    rdAccesses = 0;
    pselCycles = 0;
    for (int i = 0; i < slaveNum; i++) begin
      waitLeft[i] = '0;
      for (int j = 0; j < 256; j++) begin
        slaveMem[i][j] = fillWord(i * 'h1000 + j * 4);
      end
    end
    forever begin
      @(posedge pclk);
      #2;
      pready  = '0;
      pslverr = '0;
      prdata  = '0;
      if (|psel) begin
        pselCycles++;
      end
      for (int i = 0; i < slaveNum; i++) begin
        if (psel[i] && !apbReq.penable) begin
          lfsr = lfsrStep(lfsr);
          waitLeft[i][0] = lfsr[0];
          lfsr = lfsrStep(lfsr);
          waitLeft[i][1] = lfsr[0];
        end else if (psel[i] && waitLeft[i] != 2'd0) begin
          waitLeft[i] = waitLeft[i] - 2'd1;
        end else if (psel[i]) begin
          idx        = int'(apbReq.paddr[9:2]);
          pready[i]  = 1'b1;
          pslverr[i] = (i == 2);
          lastProt   = apbReq.pprot;
          seenAddr.push_back(apbReq.paddr);
          if (!apbReq.pwrite) begin
            prdata[i] = slaveMem[i][idx];
            rdAccesses++;
          end else if (i != 2) begin
            for (int b = 0; b < strbWidth; b++) begin
              if (apbReq.pstrb[b]) begin
                slaveMem[i][idx][8*b +: 8] = apbReq.pwdata[8*b +: 8];
              end
            end
          end
        end
      end
    end
  end

  // ======================================================================
  // APB protocol assertions
  // ======================================================================
  assert property (@(posedge pclk) disable iff (!preset_n) $onehot0(psel))
    else begin
      errors++;
      $display("psel has more than one slave selected: %b", psel);
    end

  assert property (@(posedge pclk) disable iff (!preset_n)
    apbReq.penable |-> ($past(|psel) || ($past(apbReq.paddr) >= 32'h0000_4000)))
    else begin
      errors++;
      $display("penable rose without a setup cycle before it");
    end

  assert property (@(posedge pclk) disable iff (!preset_n)
    apbReq.penable |-> $stable(apbReq.paddr))
    else begin
      errors++;
      $display("paddr changed during an access phase");
    end

  // ======================================================================
  // AXI master tasks
  // ======================================================================
  task automatic nextCycle();
    @(posedge pclk);
    #2;
  endtask

  task automatic abortRun(string what);
    errors++;
    $display("timeout while waiting for %s", what);
    aborted = 1'b1;
    forever @(posedge pclk);
  endtask

  task automatic checkValue(string name, logic [31:0] expected, logic [31:0] actual);
    checks++;
    assert (expected === actual)
      else begin
        errors++;
        $display("FAIL %s: expected %h, actual %h", name, expected, actual);
      end
  endtask

  task automatic sendAddr(input logic isWrite, input logic [31:0] addr,
                          input logic [7:0] id, input logic [7:0] len,
                          input logic [1:0] burst);
    axiAddrT req;
    int      t;
    req.addr  = addr;
    req.id    = id;
    req.len   = len;
    req.burst = burst;
    req.prot  = 3'b010;
    if (isWrite) begin
      awReq   = req;
      awvalid = 1'b1;
    end else begin
      arReq   = req;
      arvalid = 1'b1;
    end
    t = 0;
    while (isWrite ? !awready : !arready) begin
      if (t == waitLimit) begin
        abortRun("an address channel ready");
      end
      nextCycle();
      t++;
    end
    nextCycle();
    awvalid = 1'b0;
    arvalid = 1'b0;
  endtask

  task automatic sendData(input logic [31:0] data, input logic [3:0] strb);
    int t;
    wBeat.data = data;
    wBeat.strb = strb;
    wvalid     = 1'b1;
    t = 0;
    while (!wready) begin
      if (t == waitLimit) begin
        abortRun("wready");
      end
      nextCycle();
      t++;
    end
    nextCycle();
    wvalid = 1'b0;
  endtask

  task automatic expectWriteResp(string name, logic [1:0] expResp, logic [7:0] expId);
    int t;
    bready = 1'b1;
    t = 0;
    while (!bvalid) begin
      if (t == waitLimit) begin
        abortRun("bvalid");
      end
      nextCycle();
      t++;
    end
    checkValue({name, " bresp"}, expResp, bresp);
    checkValue({name, " bid"}, expId, bid);
    nextCycle();
    bready = 1'b0;
  endtask

  task automatic expectReadBeat(string name, logic [31:0] expData, logic [1:0] expResp,
                                logic [7:0] expId, logic expLast);
    int t;
    rready = 1'b1;
    t = 0;
    while (!rvalid) begin
      if (t == waitLimit) begin
        abortRun("rvalid");
      end
      nextCycle();
      t++;
    end
    checkValue({name, " rdata"}, expData, rBeat.data);
    checkValue({name, " rresp"}, expResp, rBeat.resp);
    checkValue({name, " rid"}, expId, rBeat.id);
    checkValue({name, " rlast"}, expLast, rBeat.last);
    nextCycle();
    rready = 1'b0;
  endtask

  initial begin
    wait (aborted);
    $display("checks %0d, errors %0d", checks, errors);
    $display("TESTS FAILED");
    $finish;
  end

  // ======================================================================
  // directed sequence
  // ======================================================================
  initial begin
    logic [31:0] word;
    int          k;
    int          first;
    int          base;
    preset_n = 1'b0;
    awvalid  = 1'b0;
    awReq    = '0;
    wvalid   = 1'b0;
    wBeat    = '0;
    arvalid  = 1'b0;
    arReq    = '0;
    rready   = 1'b0;
    bready   = 1'b0;
    repeat (8) @(posedge pclk);
    #2;
    preset_n = 1'b1;
    nextCycle();
    checkValue("reset psel", 0, psel);
    checkValue("reset penable", 0, apbReq.penable);
    checkValue("reset bvalid", 0, bvalid);
    checkValue("reset rvalid", 0, rvalid);

    // single strobed write then read on slave 0
    sendAddr(1'b1, 32'h10, 8'h21, 8'd0, burstIncr);
    sendData(32'hDEAD_BEEF, 4'h3);
    expectWriteResp("single write", respOkay, 8'h21);
    word = fillWord(32'h10);
    word[15:0] = 16'hBEEF;
    checkValue("single write merge", word, slaveMem[0][4]);
    checkValue("single write pprot", 3'b010, lastProt);
    sendAddr(1'b0, 32'h10, 8'h22, 8'd0, burstIncr);
    expectReadBeat("single read", word, respOkay, 8'h22, 1'b1);

    // INCR burst of four on slave 1
    first = seenAddr.size();
    sendAddr(1'b1, 32'h1020, 8'h31, 8'd3, burstIncr);
    for (k = 0; k < 4; k++) begin
      sendData(32'h1111_0000 + k, 4'hF);
    end
    expectWriteResp("incr write", respOkay, 8'h31);
    checkValue("incr beat count", 4, seenAddr.size() - first);
    for (k = 0; k < 4; k++) begin
      checkValue($sformatf("incr paddr %0d", k), 32'h1020 + 4 * k, seenAddr[first + k]);
    end
    sendAddr(1'b0, 32'h1020, 8'h32, 8'd3, burstIncr);
    for (k = 0; k < 4; k++) begin
      expectReadBeat($sformatf("incr read %0d", k), 32'h1111_0000 + k, respOkay,
                     8'h32, k == 3);
    end

    // FIXED burst of three on slave 3
    first = seenAddr.size();
    sendAddr(1'b1, 32'h3040, 8'h41, 8'd2, burstFixed);
    for (k = 0; k < 3; k++) begin
      sendData(32'h3333_0000 + k, 4'hF);
    end
    expectWriteResp("fixed write", respOkay, 8'h41);
    checkValue("fixed beat count", 3, seenAddr.size() - first);
    for (k = 0; k < 3; k++) begin
      checkValue($sformatf("fixed paddr %0d", k), 32'h3040, seenAddr[first + k]);
    end
    sendAddr(1'b0, 32'h3040, 8'h42, 8'd0, burstIncr);
    expectReadBeat("fixed read", 32'h3333_0002, respOkay, 8'h42, 1'b1);

    // out-of-map and slave error
    base = pselCycles;
    sendAddr(1'b1, 32'h8000, 8'h51, 8'd1, burstIncr);
    sendData(32'h5555_0000, 4'hF);
    sendData(32'h5555_0001, 4'hF);
    expectWriteResp("decode write", respDecErr, 8'h51);
    sendAddr(1'b0, 32'h8000, 8'h52, 8'd2, burstIncr);
    for (k = 0; k < 3; k++) begin
      expectReadBeat($sformatf("decode read %0d", k), 32'h0, respDecErr, 8'h52, k == 2);
    end
    checkValue("decode psel cycles", 0, pselCycles - base);
    sendAddr(1'b1, 32'h2000, 8'h53, 8'd0, burstIncr);
    sendData(32'h2222_2222, 4'hF);
    expectWriteResp("slave error write", respSlvErr, 8'h53);
    sendAddr(1'b0, 32'h2000, 8'h54, 8'd0, burstIncr);
    expectReadBeat("slave error read", fillWord(32'h2000), respSlvErr, 8'h54, 1'b1);

    // read queue back-pressure with a write waiting behind the burst
    base = rdAccesses;
    sendAddr(1'b0, 32'h100, 8'h71, 8'd7, burstIncr);
    k = 0;
    while (rdAccesses - base < 4) begin
      if (k == waitLimit) begin
        abortRun("four queued read beats");
      end
      nextCycle();
      k++;
    end
    repeat (20) nextCycle();
    checkValue("stalled read count", 4, rdAccesses - base);
    sendAddr(1'b1, 32'h3100, 8'h62, 8'd0, burstIncr);
    sendData(32'hCAFE_F00D, 4'hF);
    for (k = 0; k < 8; k++) begin
      expectReadBeat($sformatf("stalled read %0d", k), fillWord(32'h100 + 4 * k),
                     respOkay, 8'h71, k == 7);
    end
    expectWriteResp("stalled write", respOkay, 8'h62);
    checkValue("stalled write data", 32'hCAFE_F00D, slaveMem[3][64]);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
logic/bridgePkg.sv
logic/syncFifo.sv
logic/axiIngress.sv
logic/slaveDecoder.sv
logic/apbSequencer.sv
logic/axiResponder.sv
logic/axiApbBridge.sv
dv/bridgeTb.sv

// File: Makefile
# Verilator build and run of the AXI to APB bridge testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module bridgeTb -f sim.f

run: compile
	@out="$$(./obj_dir/VbridgeTb)"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf obj_dir
